//--- Makefile
# Verilator build and run of the I/O fabric testbench

TOP := io_subsystem_tb

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f

# pass only when the testbench prints its pass line
run: build
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

//--- common/board_pkg.sv
// Widths, types and reset values of the board display outputs.
// Used by the display registers and the top level ports.
`default_nettype none

package board_pkg;

	localparam int RED_LED_WIDTH   = 18;
	localparam int GREEN_LED_WIDTH = 9;
	localparam int NUM_HEX         = 4;       // seven segment digits on the board

	typedef logic [RED_LED_WIDTH-1:0]   red_led_t;
	typedef logic [GREEN_LED_WIDTH-1:0] green_led_t;

	// segments g..a, active low
	typedef logic [6:0] hex_digit_t;

	typedef hex_digit_t [NUM_HEX-1:0] hex_array_t;   // 28 bits, digit 0 in the low bits

	localparam hex_digit_t HEX_BLANK = 7'b1111111;   // every segment off

endpackage

`default_nettype wire

//--- common/io_pkg.sv
// I/O bus word, raw request and decoded select types plus the register address map.
// Shared by the decoder, the register blocks and the read-back path.
`default_nettype none

package io_pkg;

	typedef logic [31:0] scalar_t;                // one bus word
	typedef logic [31:0] io_addr_t;               // byte address of an io register

	// board register map, byte addresses
	localparam io_addr_t ADDR_RED_LED      = 32'h00;
	localparam io_addr_t ADDR_GREEN_LED    = 32'h04;
	localparam io_addr_t ADDR_HEX0         = 32'h08;
	localparam io_addr_t ADDR_HEX1         = 32'h0c;
	localparam io_addr_t ADDR_HEX2         = 32'h10;
	localparam io_addr_t ADDR_HEX3         = 32'h14;
	localparam io_addr_t ADDR_FB_BASE      = 32'h28;  // write only, strobe to video
	localparam io_addr_t ADDR_FRAME_TOGGLE = 32'h2c;  // read only
	localparam io_addr_t ADDR_GPIO_DIR     = 32'h58;
	localparam io_addr_t ADDR_GPIO_VALUE   = 32'h5c;

	typedef enum logic [3:0]
	{
		REG_NONE,                                 // unmapped or dropped peripheral
		REG_RED_LED,
		REG_GREEN_LED,
		REG_HEX0,
		REG_HEX1,
		REG_HEX2,
		REG_HEX3,
		REG_FB_BASE,
		REG_FRAME_TOGGLE,
		REG_GPIO_DIR,
		REG_GPIO_VALUE
	} io_reg_e;

	typedef struct packed
	{
		logic     write_en;                       // single cycle write strobe
		logic     read_en;                        // carried along, not needed by the fabric
		io_addr_t address;
		scalar_t  write_data;
	} io_req_t;                                   // 66 bits, raw processor bus

	typedef struct packed
	{
		io_reg_e sel;                             // register addressed this cycle
		logic    wr;                              // write in this cycle
		scalar_t data;                            // write data
	} io_sel_t;

endpackage

`default_nettype wire

//--- gpio/gpio_controller.sv
// Bit-bang GPIO port. Holds the direction and output registers, synchronizes
// the pin inputs and builds the value seen by a read of the GPIO value register.
`timescale 1ns/1ns
`default_nettype none

module gpio_controller
#(
	parameter int NUM_PINS = 6
)
(
	input  logic                clk,
	input  logic                reset,
	input  io_pkg::io_sel_t     sel,
	input  logic [NUM_PINS-1:0] gpio_in,
	output logic [NUM_PINS-1:0] gpio_out,
	output logic [NUM_PINS-1:0] gpio_oe,
	output logic [NUM_PINS-1:0] gpio_read_value
);

	logic [NUM_PINS-1:0] dir_reg;                // 1 drives the pin
	logic [NUM_PINS-1:0] out_reg;                // level driven on output pins
	logic [NUM_PINS-1:0] in_meta;                // first synchronizer stage
	logic [NUM_PINS-1:0] in_sync;                // second stage, safe to use

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			dir_reg <= '0;                       // all pins input after reset
			out_reg <= '0;
		end
		else if (sel.wr)
		begin
			if (sel.sel == io_pkg::REG_GPIO_DIR)
				dir_reg <= sel.data[NUM_PINS-1:0];
			if (sel.sel == io_pkg::REG_GPIO_VALUE)
				out_reg <= sel.data[NUM_PINS-1:0];
		end
	end

	// pins are asynchronous to clk, two flops before anything looks at them
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			in_meta <= '0;
			in_sync <= '0;
		end
		else
		begin
			in_meta <= gpio_in;
			in_sync <= in_meta;
		end
	end

	assign gpio_oe  = dir_reg;
	assign gpio_out = out_reg;

	// output pins read back what we drive, input pins what the board drives
	assign gpio_read_value = (out_reg & dir_reg) | (in_sync & ~dir_reg);

endmodule

`default_nettype wire

//--- list.f
common/io_pkg.sv
common/board_pkg.sv
logic/io_decoder.sv
logic/display_regs.sv
gpio/gpio_controller.sv
logic/io_read_mux.sv
logic/io_subsystem.sv
sim/io_subsystem_assert.sv
sim/io_subsystem_tb.sv

//--- logic/display_regs.sv
// LED and seven segment display registers. Each register takes the low bits
// of the bus word on a write to its select, digits come out of reset blank.
`timescale 1ns/1ns
`default_nettype none

module display_regs
(
	input  logic                  clk,
	input  logic                  reset,
	input  io_pkg::io_sel_t       sel,
	output board_pkg::red_led_t   red_led,
	output board_pkg::green_led_t green_led,
	output board_pkg::hex_array_t hex
);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			red_led   <= '0;
			green_led <= '0;
			hex       <= {board_pkg::NUM_HEX{board_pkg::HEX_BLANK}};   // all digits dark
		end
		else if (sel.wr)
		begin
			case (sel.sel)
				io_pkg::REG_RED_LED:
					red_led <= sel.data[board_pkg::RED_LED_WIDTH-1:0];
				io_pkg::REG_GREEN_LED:
					green_led <= sel.data[board_pkg::GREEN_LED_WIDTH-1:0];
				io_pkg::REG_HEX0:
					hex[0] <= sel.data[$bits(board_pkg::hex_digit_t)-1:0];
				io_pkg::REG_HEX1:
					hex[1] <= sel.data[$bits(board_pkg::hex_digit_t)-1:0];
				io_pkg::REG_HEX2:
					hex[2] <= sel.data[$bits(board_pkg::hex_digit_t)-1:0];
				io_pkg::REG_HEX3:
					hex[3] <= sel.data[$bits(board_pkg::hex_digit_t)-1:0];
				default:
				begin
					// other registers live elsewhere, hold everything
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/io_decoder.sv
// Address decoder of the I/O bus. Turns each raw request into a register select
// and generates the framebuffer base update strobe combinationally.
`timescale 1ns/1ns
`default_nettype none

module io_decoder
(
	input  io_pkg::io_req_t req,
	output io_pkg::io_sel_t sel,
	output logic            fb_base_update_en,
	output io_pkg::scalar_t fb_new_base
);

	io_pkg::io_reg_e reg_sel;                     // decoded register

	always_comb
	begin
		case (req.address)
			io_pkg::ADDR_RED_LED:      reg_sel = io_pkg::REG_RED_LED;
			io_pkg::ADDR_GREEN_LED:    reg_sel = io_pkg::REG_GREEN_LED;
			io_pkg::ADDR_HEX0:         reg_sel = io_pkg::REG_HEX0;
			io_pkg::ADDR_HEX1:         reg_sel = io_pkg::REG_HEX1;
			io_pkg::ADDR_HEX2:         reg_sel = io_pkg::REG_HEX2;
			io_pkg::ADDR_HEX3:         reg_sel = io_pkg::REG_HEX3;
			io_pkg::ADDR_FB_BASE:      reg_sel = io_pkg::REG_FB_BASE;
			io_pkg::ADDR_FRAME_TOGGLE: reg_sel = io_pkg::REG_FRAME_TOGGLE;
			io_pkg::ADDR_GPIO_DIR:     reg_sel = io_pkg::REG_GPIO_DIR;
			io_pkg::ADDR_GPIO_VALUE:   reg_sel = io_pkg::REG_GPIO_VALUE;
			default:                   reg_sel = io_pkg::REG_NONE;   // uart, ps2 and holes read zero
		endcase
	end

	assign sel.sel  = reg_sel;
	assign sel.wr   = req.write_en;                // reads need no strobe, mux samples every cycle
	assign sel.data = req.write_data;

	// framebuffer base goes straight to the video side in the write cycle
	assign fb_base_update_en = req.write_en && reg_sel == io_pkg::REG_FB_BASE;
	assign fb_new_base       = req.write_data;

endmodule

`default_nettype wire

//--- logic/io_read_mux.sv
// Registered read-back path. Samples the value of the currently selected
// register on every clock, so read data follows the address by one cycle.
`timescale 1ns/1ns
`default_nettype none

module io_read_mux
#(
	parameter int NUM_PINS = 6
)
(
	input  logic                clk,
	input  logic                reset,
	input  io_pkg::io_sel_t     sel,
	input  logic                frame_toggle,
	input  logic [NUM_PINS-1:0] gpio_read_value,
	output io_pkg::scalar_t     io_read_data
);

	io_pkg::scalar_t read_value;                 // zero extended value of the select

	always_comb
	begin
		case (sel.sel)
			io_pkg::REG_FRAME_TOGGLE:
				read_value = io_pkg::scalar_t'(frame_toggle);      // level in bit 0
			io_pkg::REG_GPIO_VALUE:
				read_value = io_pkg::scalar_t'(gpio_read_value);
			default:
				read_value = '0;                     // write only and unmapped registers
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			io_read_data <= '0;
		else
			io_read_data <= read_value;          // every cycle, read_en not needed
	end

endmodule

`default_nettype wire

//--- logic/io_subsystem.sv
// Top of the memory-mapped I/O fabric. The processor bus comes in as one request
// and fans out to the LED, digit and GPIO registers and the read-back path.
`timescale 1ns/1ns
`default_nettype none

module io_subsystem
#(
	parameter int NUM_PINS = 6                   // bit-bang pins, sd card on the board
)
(
	input  logic                  clk,
	input  logic                  reset,
	input  io_pkg::io_req_t       req,
	input  logic                  frame_toggle,  // from the video side
	input  logic [NUM_PINS-1:0]   gpio_in,
	output board_pkg::red_led_t   red_led,
	output board_pkg::green_led_t green_led,
	output board_pkg::hex_array_t hex,
	output logic [NUM_PINS-1:0]   gpio_out,
	output logic [NUM_PINS-1:0]   gpio_oe,       // pads live in the board wrapper
	output logic                  fb_base_update_en,
	output io_pkg::scalar_t       fb_new_base,
	output io_pkg::scalar_t       io_read_data
);

	io_pkg::io_sel_t     sel;                    // decoded request, shared by all blocks
	logic [NUM_PINS-1:0] gpio_read_value;

	io_decoder i_decoder
	(
		.req               (req),
		.sel               (sel),
		.fb_base_update_en (fb_base_update_en),
		.fb_new_base       (fb_new_base)
	);

	display_regs i_display_regs
	(
		.clk       (clk),
		.reset     (reset),
		.sel       (sel),
		.red_led   (red_led),
		.green_led (green_led),
		.hex       (hex)
	);

	gpio_controller #(.NUM_PINS(NUM_PINS)) i_gpio_controller
	(
		.clk             (clk),
		.reset           (reset),
		.sel             (sel),
		.gpio_in         (gpio_in),
		.gpio_out        (gpio_out),
		.gpio_oe         (gpio_oe),
		.gpio_read_value (gpio_read_value)
	);

	io_read_mux #(.NUM_PINS(NUM_PINS)) i_read_mux
	(
		.clk             (clk),
		.reset           (reset),
		.sel             (sel),
		.frame_toggle    (frame_toggle),
		.gpio_read_value (gpio_read_value),
		.io_read_data    (io_read_data)
	);

endmodule

`default_nettype wire

//--- sim/io_subsystem_assert.sv
// Concurrent checks on the I/O fabric top level, attached with bind.
// Covers the video strobe, the gpio direction, the digit reset and unmapped reads.
`timescale 1ns/1ns
`default_nettype none

module io_subsystem_assert
#(
	parameter int NUM_PINS = 6
)
(
	input  logic                  clk,
	input  logic                  reset,
	input  io_pkg::io_req_t       req,
	input  io_pkg::io_sel_t       sel,
	input  logic                  fb_base_update_en,
	input  logic [NUM_PINS-1:0]   gpio_oe,
	input  board_pkg::hex_array_t hex,
	input  io_pkg::scalar_t       io_read_data,
	output logic                  any_failed
);

	bit strobe_err = 1'b0;
	bit oe_err     = 1'b0;
	bit blank_err  = 1'b0;
	bit none_err   = 1'b0;

	assign any_failed = strobe_err | oe_err | blank_err | none_err;

	// video strobe only with a bus write to the base register
	strobe_needs_write: assert property (@(posedge clk)
		fb_base_update_en |-> (req.write_en && req.address == io_pkg::ADDR_FB_BASE))
	else
	begin
		strobe_err = 1'b1;
		$error("framebuffer strobe without a write");
	end

	// oe takes the word of a dir write
	oe_takes_dir: assert property (@(posedge clk) disable iff (reset)
		(sel.wr && sel.sel == io_pkg::REG_GPIO_DIR) |=> (gpio_oe == $past(sel.data[NUM_PINS-1:0])))
	else
	begin
		oe_err = 1'b1;
		$error("gpio_oe differs from the written direction");
	end

	// and holds it until the next one
	oe_holds: assert property (@(posedge clk) disable iff (reset)
		!(sel.wr && sel.sel == io_pkg::REG_GPIO_DIR) |=> $stable(gpio_oe))
	else
	begin
		oe_err = 1'b1;
		$error("gpio_oe changed without a direction write");
	end

	hex_blank_in_reset: assert property (@(posedge clk)
		reset |-> (hex == {board_pkg::NUM_HEX{board_pkg::HEX_BLANK}}))
	else
	begin
		blank_err = 1'b1;
		$error("digits not blank during reset");
	end

	// holes and dropped peripherals read zero
	none_reads_zero: assert property (@(posedge clk) disable iff (reset)
		(sel.sel == io_pkg::REG_NONE) |=> (io_read_data == '0))
	else
	begin
		none_err = 1'b1;
		$error("unmapped address returned nonzero read data");
	end

endmodule

bind io_subsystem io_subsystem_assert #(.NUM_PINS(NUM_PINS)) i_assert
(
	.clk               (clk),
	.reset             (reset),
	.req               (req),
	.sel               (sel),
	.fb_base_update_en (fb_base_update_en),
	.gpio_oe           (gpio_oe),
	.hex               (hex),
	.io_read_data      (io_read_data),
	.any_failed        ()
);

`default_nettype wire

//--- sim/io_subsystem_tb.sv
// Testbench of the I/O fabric. Plays a table of bus steps into the DUT, keeps a model
// of the board registers and checks every output and the registered read data.
`timescale 1ns/1ns
`default_nettype none

module io_subsystem_tb;

	localparam int NUM_PINS = 6;

	typedef struct packed
	{
		logic [2:0]            test_id;          // groups steps into tests
		logic                  wr;               // 1 write, 0 read
		io_pkg::io_addr_t      addr;
		io_pkg::scalar_t       data;
		logic [NUM_PINS-1:0]   gin;              // level on the gpio pins
		logic                  ft;               // frame toggle level
		logic                  exp_fb;           // strobe expected this cycle
		logic                  chk_read;         // read data known for this step
		io_pkg::scalar_t       exp_read;
		board_pkg::red_led_t   exp_red;
		board_pkg::green_led_t exp_green;
		board_pkg::hex_array_t exp_hex;
		logic [NUM_PINS-1:0]   exp_dir;
		logic [NUM_PINS-1:0]   exp_out;
	} step_t;

	logic                  clk;
	logic                  reset;
	io_pkg::io_req_t       req;
	logic                  frame_toggle;
	logic [NUM_PINS-1:0]   gpio_in;
	board_pkg::red_led_t   red_led;
	board_pkg::green_led_t green_led;
	board_pkg::hex_array_t hex;
	logic [NUM_PINS-1:0]   gpio_out;
	logic [NUM_PINS-1:0]   gpio_oe;
	logic                  fb_base_update_en;
	io_pkg::scalar_t       fb_new_base;
	io_pkg::scalar_t       io_read_data;

	step_t                 steps[$];         // stimulus and expected values
	integer                seed   = 98104;
	int                    checks = 0;
	int                    errors = 0;
	int                    tests  = 0;

	board_pkg::red_led_t   m_red;            // register model
	board_pkg::green_led_t m_green;
	board_pkg::hex_array_t m_hex;
	logic [NUM_PINS-1:0]   m_dir;
	logic [NUM_PINS-1:0]   m_out;
	logic [NUM_PINS-1:0]   prev_gin;         // pin level of the previous step
	int                    gin_age;          // steps since the pins last changed

	io_subsystem #(.NUM_PINS(NUM_PINS)) i_dut
	(
		.clk               (clk),
		.reset             (reset),
		.req               (req),
		.frame_toggle      (frame_toggle),
		.gpio_in           (gpio_in),
		.red_led           (red_led),
		.green_led         (green_led),
		.hex               (hex),
		.gpio_out          (gpio_out),
		.gpio_oe           (gpio_oe),
		.fb_base_update_en (fb_base_update_en),
		.fb_new_base       (fb_new_base),
		.io_read_data      (io_read_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;                   // 10 ns period
	end

	task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd0:    return "reset values";
			3'd1:    return "display writes";
			3'd2:    return "framebuffer strobe";
			3'd3:    return "gpio direction and value";
			3'd4:    return "frame toggle and unmapped reads";
			default: return "unnamed";
		endcase
	endfunction

	// value the read path should register for an address, pins assumed settled
	function automatic io_pkg::scalar_t expected_read(input io_pkg::io_addr_t addr,
		input logic [NUM_PINS-1:0] gin, input logic ft);
		io_pkg::scalar_t pin_word;
		pin_word = '0;
		for (int i = 0; i < NUM_PINS; i++)
			pin_word[i] = m_dir[i] ? m_out[i] : gin[i];   // output pins read the driven level
		case (addr)
			io_pkg::ADDR_FRAME_TOGGLE: return io_pkg::scalar_t'(ft);
			io_pkg::ADDR_GPIO_VALUE:   return pin_word;
			default:                   return '0;   // write only, dropped or unmapped
		endcase
	endfunction

	task automatic model_write(input io_pkg::io_addr_t addr, input io_pkg::scalar_t data);
		case (addr)
			io_pkg::ADDR_RED_LED:    m_red    = data[board_pkg::RED_LED_WIDTH-1:0];
			io_pkg::ADDR_GREEN_LED:  m_green  = data[board_pkg::GREEN_LED_WIDTH-1:0];
			io_pkg::ADDR_HEX0:       m_hex[0] = data[6:0];
			io_pkg::ADDR_HEX1:       m_hex[1] = data[6:0];
			io_pkg::ADDR_HEX2:       m_hex[2] = data[6:0];
			io_pkg::ADDR_HEX3:       m_hex[3] = data[6:0];
			io_pkg::ADDR_GPIO_DIR:   m_dir    = data[NUM_PINS-1:0];
			io_pkg::ADDR_GPIO_VALUE: m_out    = data[NUM_PINS-1:0];
			default:
			begin
				// fb base and holes keep no state here
			end
		endcase
	endtask

	task automatic add_step(input logic [2:0] test_id, input logic wr, input io_pkg::io_addr_t addr,
		input io_pkg::scalar_t data, input logic [NUM_PINS-1:0] gin, input logic ft);
		step_t s;
		if (gin != prev_gin)
			gin_age = 0;
		else
			gin_age++;
		prev_gin   = gin;
		s.test_id  = test_id;
		s.wr       = wr;
		s.addr     = addr;
		s.data     = data;
		s.gin      = gin;
		s.ft       = ft;
		s.exp_fb   = wr && addr == io_pkg::ADDR_FB_BASE;
		s.chk_read = addr != io_pkg::ADDR_GPIO_VALUE || gin_age >= 4;   // synchronizer settled
		s.exp_read = expected_read(addr, gin, ft);   // mux sees the state before the write
		if (wr)
			model_write(addr, data);
		s.exp_red   = m_red;
		s.exp_green = m_green;
		s.exp_hex   = m_hex;
		s.exp_dir   = m_dir;
		s.exp_out   = m_out;
		steps.push_back(s);
	endtask

	task automatic build_table();
		logic [NUM_PINS-1:0] pins;
		io_pkg::scalar_t     dir_word;
		m_red    = '0;
		m_green  = '0;
		m_hex    = {board_pkg::NUM_HEX{board_pkg::HEX_BLANK}};
		m_dir    = '0;
		m_out    = '0;
		prev_gin = '0;
		gin_age  = 100;                          // pins low since reset
		pins     = '0;
		add_step(3'd1, 1'b1, io_pkg::ADDR_RED_LED,   $random(seed), pins, 1'b0);
		add_step(3'd1, 1'b1, io_pkg::ADDR_GREEN_LED, $random(seed), pins, 1'b0);
		add_step(3'd1, 1'b1, io_pkg::ADDR_HEX0,      $random(seed), pins, 1'b0);
		add_step(3'd1, 1'b1, io_pkg::ADDR_HEX1,      $random(seed), pins, 1'b0);
		add_step(3'd1, 1'b1, io_pkg::ADDR_HEX2,      $random(seed), pins, 1'b0);
		add_step(3'd1, 1'b1, io_pkg::ADDR_HEX3,      $random(seed), pins, 1'b0);
		add_step(3'd1, 1'b0, io_pkg::ADDR_HEX0,      $random(seed), pins, 1'b0);   // read, no change
		add_step(3'd1, 1'b1, io_pkg::ADDR_RED_LED,   $random(seed), pins, 1'b0);
		add_step(3'd2, 1'b1, io_pkg::ADDR_FB_BASE,   $random(seed), pins, 1'b0);
		add_step(3'd2, 1'b0, io_pkg::ADDR_FB_BASE,   $random(seed), pins, 1'b0);   // read, no strobe
		add_step(3'd2, 1'b1, io_pkg::ADDR_GREEN_LED, $random(seed), pins, 1'b0);
		add_step(3'd2, 1'b1, io_pkg::ADDR_FB_BASE,   $random(seed), pins, 1'b0);
		add_step(3'd2, 1'b0, io_pkg::ADDR_RED_LED,   $random(seed), pins, 1'b0);
		pins     = NUM_PINS'($random(seed));
		dir_word = $random(seed);
		add_step(3'd3, 1'b1, io_pkg::ADDR_GPIO_DIR,   dir_word, pins, 1'b0);
		add_step(3'd3, 1'b1, io_pkg::ADDR_GPIO_VALUE, $random(seed), pins, 1'b0);
		repeat (5)
			add_step(3'd3, 1'b0, io_pkg::ADDR_GPIO_VALUE, '0, pins, 1'b0);
		pins = ~pins;                            // every input pin flips
		repeat (6)
			add_step(3'd3, 1'b0, io_pkg::ADDR_GPIO_VALUE, '0, pins, 1'b0);
		add_step(3'd3, 1'b1, io_pkg::ADDR_GPIO_DIR, ~dir_word, pins, 1'b0);   // swap directions
		repeat (2)
			add_step(3'd3, 1'b0, io_pkg::ADDR_GPIO_VALUE, '0, pins, 1'b0);
		add_step(3'd4, 1'b0, io_pkg::ADDR_FRAME_TOGGLE, '0, pins, 1'b1);
		add_step(3'd4, 1'b0, io_pkg::ADDR_FRAME_TOGGLE, '0, pins, 1'b0);
		add_step(3'd4, 1'b0, io_pkg::ADDR_FRAME_TOGGLE, '0, pins, 1'b1);
		add_step(3'd4, 1'b0, 32'h18, '0, pins, 1'b1);   // uart, gone
		add_step(3'd4, 1'b0, 32'h38, '0, pins, 1'b1);   // ps2, gone
		repeat (3)
			add_step(3'd4, 1'b0,
				32'h0001_0000 | (io_pkg::io_addr_t'($random(seed)) & 32'h0000_fffc),
				'0, pins, 1'b1);
	endtask

	task automatic apply_step(input step_t s);
		req.write_en   = s.wr;
		req.read_en    = ~s.wr;
		req.address    = s.addr;
		req.write_data = s.data;
		gpio_in        = s.gin;
		frame_toggle   = s.ft;
		@(negedge clk);                          // strobe is combinational, look mid cycle
		check_value("fb_base_update_en", 64'(fb_base_update_en), 64'(s.exp_fb));
		if (s.exp_fb)
			check_value("fb_new_base", 64'(fb_new_base), 64'(s.data));
		@(posedge clk);
		#1;
		check_value("red_led", 64'(red_led), 64'(s.exp_red));
		check_value("green_led", 64'(green_led), 64'(s.exp_green));
		check_value("hex", 64'(hex), 64'(s.exp_hex));
		check_value("gpio_oe", 64'(gpio_oe), 64'(s.exp_dir));
		check_value("gpio_out", 64'(gpio_out), 64'(s.exp_out));
		if (s.chk_read)
			check_value("io_read_data", 64'(io_read_data), 64'(s.exp_read));
	endtask

	task automatic wait_outputs_known(output bit ok);
		int cycles;
		ok     = 1'b0;
		cycles = 0;
		while (!ok && cycles < 10)               // bounded
		begin
			@(posedge clk);
			#1;
			ok = !$isunknown({red_led, green_led, hex, gpio_oe, gpio_out, io_read_data});
			cycles++;
		end
	endtask

	task automatic check_reset();
		check_value("red_led", 64'(red_led), 64'(0));
		check_value("green_led", 64'(green_led), 64'(0));
		check_value("hex", 64'(hex), 64'(28'hfff_ffff));   // every segment off
		check_value("gpio_oe", 64'(gpio_oe), 64'(0));
		check_value("gpio_out", 64'(gpio_out), 64'(0));
		check_value("fb_base_update_en", 64'(fb_base_update_en), 64'(0));
		check_value("io_read_data", 64'(io_read_data), 64'(0));
	endtask

	task automatic report_test(input logic [2:0] id, input int err_start);
		tests++;
		if (errors == err_start)
			$display("test %0d, %s: passed", id, test_name(id));
		else
			$display("test %0d, %s: failed with %0d errors", id, test_name(id), errors - err_start);
	endtask

	initial
	begin
		bit         known;
		logic [2:0] cur_test;
		int         err_start;
		reset        = 1'b1;
		req          = '0;
		frame_toggle = 1'b0;
		gpio_in      = '0;
		build_table();
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		wait_outputs_known(known);
		if (!known)
			$display("DUT outputs still unknown 10 cycles after reset release");
		else
		begin
			err_start = errors;
			check_reset();
			report_test(3'd0, err_start);
			cur_test  = steps[0].test_id;
			err_start = errors;
			foreach (steps[i])
			begin
				if (steps[i].test_id != cur_test)
				begin
					report_test(cur_test, err_start);
					cur_test  = steps[i].test_id;
					err_start = errors;
				end
				apply_step(steps[i]);
			end
			report_test(cur_test, err_start);
			req = '0;                            // bus idle
		end
		if (i_dut.i_assert.any_failed)
			$display("a concurrent assertion on the DUT fired");
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (known && errors == 0 && !i_dut.i_assert.any_failed)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
